/* Makefile */
# Verilator build and run of the CPU-side bus testbench

VERILATOR ?= verilator
TOP ?= tb_nes_bus
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "No errors" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
source/nes_timing_pkg.sv
source/nes_bus_pkg.sv
source/clock_enables.sv
source/dma_controller.sv
source/bus_arbiter.sv
source/nes_bus_top.sv
tb/tb_nes_bus.sv

/* source/bus_arbiter.sv */
// CPU/DMA bus mux, chip selects, joypad latch, open bus latch and read data mux
`timescale 1ns/10ps

module bus_arbiter (
	input logic clk,
	input logic reset,
	input logic cpu_ce,
	input logic cart_slot,
	input nes_bus_pkg::addr_t cpu_addr,
	input logic cpu_rnw,
	input nes_bus_pkg::data_t cpu_dout,
	input logic dma_active,
	input nes_bus_pkg::addr_t dma_addr,
	input logic dma_read,
	input nes_bus_pkg::data_t dma_data,
	input nes_bus_pkg::data_t mem_din,
	input nes_bus_pkg::joy_data_t joypad1_data,
	input nes_bus_pkg::joy_data_t joypad2_data,
	output nes_bus_pkg::data_t bus_data,
	output logic sprite_trigger,
	output nes_bus_pkg::addr_t mem_addr,
	output logic mem_read,
	output logic mem_write,
	output nes_bus_pkg::data_t mem_dout,
	output logic [2:0] joypad_out,
	output logic [1:0] joypad_clock
);
	import nes_bus_pkg::*;

	addr_t bus_addr;
	data_t bus_dout;
	logic bus_read;
	logic bus_write;
	logic apu_cs;
	logic joy1_cs;
	logic joy2_cs;
	data_t open_bus;	// Last byte seen on the data bus

	// DMA owns the bus whenever it asks for it
	assign bus_addr = dma_active ? dma_addr : cpu_addr;
	assign bus_dout = dma_active ? dma_data : cpu_dout;
	assign bus_read = dma_active ? dma_read : cpu_rnw;
	assign bus_write = !bus_read;

	// Address decode
	assign apu_cs = (bus_addr >= APU_BASE) && (bus_addr < APU_END);
	assign joy1_cs = (bus_addr == JOY1_ADDR);
	assign joy2_cs = (bus_addr == JOY2_ADDR);

	assign sprite_trigger = cpu_ce && bus_write && (bus_addr == SPRITE_DMA_ADDR);

	// PPU and cart share one port, strobed once per CPU cycle
	assign mem_addr = bus_addr;
	assign mem_dout = bus_dout;
	assign mem_read = cart_slot && bus_read && !apu_cs;
	assign mem_write = cart_slot && bus_write && !apu_cs;

	// Joypad strobe bits
	always_ff @(posedge clk) begin
		if (reset)
			joypad_out <= 3'd0;
		else if (cpu_ce && joy1_cs && bus_write)
			joypad_out <= bus_dout[2:0];
	end

	// Shift the pad once the read byte has been taken
	assign joypad_clock = {joy2_cs && bus_read && cpu_ce, joy1_cs && bus_read && cpu_ce};

	always_ff @(posedge clk)
		open_bus <= bus_data;	// Undriven reads keep the previous byte

	always_comb begin
		if (joy1_cs)
			bus_data = {open_bus[7:5], joypad1_data};
		else if (joy2_cs)
			bus_data = {open_bus[7:5], joypad2_data};
		else if (apu_cs)
			bus_data = open_bus;	// $4015 included
		else
			bus_data = mem_din;
	end

	// One single strobe per cart slot
	assert property (@(posedge clk) disable iff (reset)
		(mem_read || mem_write) |-> !(mem_read && mem_write) ##1 !(mem_read || mem_write))
		else $error("Memory strobes overlap or last longer than one clock");

endmodule

/* source/clock_enables.sv */
// CPU and PPU tick generation with PAL stretch, cart slot and even/odd cycle flag
`timescale 1ns/10ps

module clock_enables (
	input logic clk,
	input logic reset,
	input nes_timing_pkg::sys_type_t sys_type,
	output logic cpu_ce,
	output logic ppu_ce,
	output logic cart_slot,
	output logic odd_cycle
);
	import nes_timing_pkg::*;

	cpu_div_t div_cpu;		// Counts 1..12 through the CPU cycle
	ppu_div_t div_ppu;		// Counts 1..4 through the PPU tick
	logic [1:0] ppu_tick;		// PPU ticks already seen in this CPU cycle
	logic [2:0] cpu_tick_count;	// Position in the PAL group of five
	sys_type_t last_sys_type;
	logic stretch_cycle;
	logic stall_cpu;

	// Ticks fall on the last master clock of each period
	assign cpu_ce = (div_cpu == CPU_DIV);
	assign ppu_ce = (div_ppu == PPU_DIV);

	// Fifth PAL cycle holds the CPU divider during its first PPU tick
	assign stretch_cycle = (cpu_tick_count == PAL_CYCLE_GROUP);
	assign stall_cpu = stretch_cycle && (ppu_tick == 2'd0);

	// First PPU tick where the CPU address is settled, one later when stretched
	assign cart_slot = ppu_ce && (ppu_tick == (stretch_cycle ? 2'd1 : 2'd0));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu <= cpu_div_t'(1);
			div_ppu <= ppu_div_t'(1);
			ppu_tick <= 2'd0;
			cpu_tick_count <= 3'd0;
			odd_cycle <= 1'b1;	// First cycle out of reset is odd
			last_sys_type <= sys_type;
		end else if (sys_type != last_sys_type) begin
			// Realign everything to a fresh CPU cycle on a timing switch
			div_cpu <= cpu_div_t'(1);
			div_ppu <= ppu_div_t'(1);
			ppu_tick <= 2'd0;
			cpu_tick_count <= 3'd0;
			last_sys_type <= sys_type;
		end else begin
			if (!stall_cpu)
				div_cpu <= cpu_ce ? cpu_div_t'(1) : div_cpu + 1'b1;
			div_ppu <= ppu_ce ? ppu_div_t'(1) : div_ppu + 1'b1;

			// Tick count restarts with every CPU cycle
			if (cpu_ce)
				ppu_tick <= 2'd0;
			else if (ppu_ce)
				ppu_tick <= ppu_tick + 2'd1;

			// Group counter only runs in PAL, stays at 0 for NTSC
			if (cpu_ce && sys_type[0])
				cpu_tick_count <= stretch_cycle ? 3'd0 : cpu_tick_count + 3'd1;

			if (cpu_ce)
				odd_cycle <= ~odd_cycle;
		end
	end

	// Divider restarts on reset so no CPU tick may follow a reset clock
	assert property (@(posedge clk) reset |=> !cpu_ce)
		else $error("CPU tick on the clock after reset");

endmodule

/* source/dma_controller.sv */
// Sprite and DMC DMA state machines with the DMA bus request
`timescale 1ns/10ps

module dma_controller (
	input logic clk,
	input logic reset,
	input logic cpu_ce,
	input logic odd_cycle,
	input logic sprite_trigger,		// Write to $4014 at a CPU tick
	input logic cpu_rnw,
	input nes_bus_pkg::data_t page,		// Source page written by the CPU
	input nes_bus_pkg::data_t bus_data,	// Byte read on this cycle
	input logic dmc_req,
	input nes_bus_pkg::addr_t dmc_addr,
	output logic dma_active,
	output nes_bus_pkg::addr_t dma_addr,
	output logic dma_read,
	output nes_bus_pkg::data_t dma_data,
	output logic dmc_ack,
	output logic pause_cpu
);
	import nes_bus_pkg::*;

	spr_state_t spr_state;
	logic dmc_state;		// Request accepted, waiting for the next even cycle
	addr_t spr_addr;		// Sprite source address
	data_t last_byte;		// Byte from the last sprite read
	logic [8:0] spr_addr_next;	// Carry out marks the end of the page

	assign spr_addr_next = {1'b0, spr_addr[7:0]} + 9'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
			dmc_state <= 1'b0;
		end else if (cpu_ce) begin
			// DMC takes an even read cycle and steals the following even one
			if (!dmc_state && dmc_req && cpu_rnw && !odd_cycle)
				dmc_state <= 1'b1;
			if (dmc_state && !odd_cycle)
				dmc_state <= 1'b0;

			case (spr_state)
				SPR_IDLE: begin
					if (sprite_trigger)
						spr_state <= SPR_ALIGN;
				end
				SPR_ALIGN: begin
					if (cpu_rnw && odd_cycle)
						spr_state <= SPR_RUN;	// Next cycle is an even read
				end
				SPR_RUN: begin
					if (odd_cycle) begin
						if (spr_addr_next[8])
							spr_state <= SPR_IDLE;	// Byte $FF written
					end else if (dmc_state) begin
						spr_state <= SPR_ALIGN;	// DMC owns this even cycle
					end
				end
				default: spr_state <= SPR_IDLE;
			endcase
		end
	end

	// Source address and data byte
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (spr_state == SPR_IDLE && sprite_trigger)
				spr_addr <= {page, 8'h00};
			if (spr_state == SPR_RUN) begin
				if (odd_cycle)
					spr_addr[7:0] <= spr_addr_next[7:0];	// Advance after each write
				else
					last_byte <= bus_data;
			end
		end
	end

	assign dmc_ack = dmc_state && !odd_cycle;
	assign dma_active = dmc_ack || (spr_state == SPR_RUN);
	assign dma_read = !odd_cycle;	// Reads even, writes odd
	assign dma_data = last_byte;

	// DMC fetch wins the even cycle over the sprite read
	assign dma_addr = dmc_ack ? dmc_addr : (!odd_cycle ? spr_addr : OAM_DATA_ADDR);

	assign pause_cpu = (spr_state != SPR_IDLE) || dmc_req || dmc_state;

	// Acknowledge lasts one even CPU cycle
	assert property (@(posedge clk) disable iff (reset)
		(cpu_ce && dmc_ack) |-> !odd_cycle ##1 !dmc_ack)
		else $error("DMC acknowledge on odd cycle or longer than one tick");

	// Bus is only taken once the CPU was already halted the clock before
	assert property (@(posedge clk) disable iff (reset) dma_active |-> $past(pause_cpu))
		else $error("DMA drives the bus without a paused CPU");

endmodule

/* source/nes_bus_pkg.sv */
// CPU bus widths, register addresses, APU decode range and sprite DMA states
package nes_bus_pkg;

	// Bus widths
	typedef logic [15:0] addr_t;	// CPU address
	typedef logic [7:0] data_t;	// One bus byte
	typedef logic [4:0] joy_data_t;	// Serial bits from one joypad port

	// Writing the page number here starts a 256 byte sprite copy
	localparam addr_t SPRITE_DMA_ADDR = 16'h4014;

	// PPU sprite data port, target of every DMA write
	localparam addr_t OAM_DATA_ADDR = 16'h2004;

	// Joypad registers
	localparam addr_t JOY1_ADDR = 16'h4016;	// Strobe on write, port 1 on read
	localparam addr_t JOY2_ADDR = 16'h4017;	// Port 2 on read

	// APU register window, end is exclusive
	// Everything inside reads back as open bus except the joypads
	localparam addr_t APU_BASE = 16'h4000;
	localparam addr_t APU_END = 16'h4018;

	// Sprite DMA engine
	typedef enum logic [1:0] {
		SPR_IDLE,	// No copy pending
		SPR_ALIGN,	// CPU halted, waiting for an odd read cycle
		SPR_RUN		// Reads on even cycles, writes $2004 on odd cycles
	} spr_state_t;

endpackage

/* source/nes_bus_top.sv */
// CPU-side bus top level with clock enables, DMA engine and bus arbiter
`timescale 1ns/10ps

module nes_bus_top (
	input logic clk,
	input logic reset,
	input nes_bus_pkg::addr_t cpu_addr,
	input logic cpu_rnw,
	input nes_bus_pkg::data_t cpu_dout,
	input logic dmc_req,
	input nes_bus_pkg::addr_t dmc_addr,
	input nes_timing_pkg::sys_type_t sys_type,
	input nes_bus_pkg::joy_data_t joypad1_data,
	input nes_bus_pkg::joy_data_t joypad2_data,
	input nes_bus_pkg::data_t mem_din,
	output logic cpu_ce,
	output logic ppu_ce,
	output logic odd_cycle,
	output logic pause_cpu,
	output logic dmc_ack,
	output nes_bus_pkg::data_t cpu_din,
	output nes_bus_pkg::addr_t mem_addr,
	output logic mem_read,
	output logic mem_write,
	output nes_bus_pkg::data_t mem_dout,
	output logic [2:0] joypad_out,
	output logic [1:0] joypad_clock
);
	import nes_bus_pkg::*;

	logic cart_slot;
	logic sprite_trigger;
	logic dma_active;
	addr_t dma_addr;
	logic dma_read;
	data_t dma_data;

	clock_enables u_clock_enables (
		.clk       (clk),
		.reset     (reset),
		.sys_type  (sys_type),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.cart_slot (cart_slot),
		.odd_cycle (odd_cycle)
	);

	dma_controller u_dma_controller (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.cpu_rnw        (cpu_rnw),
		.page           (cpu_dout),	// Page byte of the $4014 write
		.bus_data       (cpu_din),	// Same byte the CPU would read
		.dmc_req        (dmc_req),
		.dmc_addr       (dmc_addr),
		.dma_active     (dma_active),
		.dma_addr       (dma_addr),
		.dma_read       (dma_read),
		.dma_data       (dma_data),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	bus_arbiter u_bus_arbiter (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.cart_slot      (cart_slot),
		.cpu_addr       (cpu_addr),
		.cpu_rnw        (cpu_rnw),
		.cpu_dout       (cpu_dout),
		.dma_active     (dma_active),
		.dma_addr       (dma_addr),
		.dma_read       (dma_read),
		.dma_data       (dma_data),
		.mem_din        (mem_din),
		.joypad1_data   (joypad1_data),
		.joypad2_data   (joypad2_data),
		.bus_data       (cpu_din),
		.sprite_trigger (sprite_trigger),
		.mem_addr       (mem_addr),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_dout       (mem_dout),
		.joypad_out     (joypad_out),
		.joypad_clock   (joypad_clock)
	);

endmodule

/* source/nes_timing_pkg.sv */
// Master-clock divider constants, system type encoding and divider counter types
package nes_timing_pkg;

	// Divider counter types
	typedef logic [4:0] cpu_div_t;	// Master clocks into the current CPU cycle
	typedef logic [2:0] ppu_div_t;	// Master clocks into the current PPU tick

	// Console system type, bit 0 selects PAL timing
	typedef logic [1:0] sys_type_t;

	// NTSC CPU cycle is 12 master clocks
	localparam cpu_div_t CPU_DIV = 5'd12;

	// One PPU dot every 4 master clocks on both systems
	localparam ppu_div_t PPU_DIV = 3'd4;

	// PAL stretches the last cycle of each group of five by one PPU tick
	// so that five CPU cycles span 64 master clocks
	localparam logic [2:0] PAL_CYCLE_GROUP = 3'd4;

endpackage

/* tb/tb_nes_bus.sv */
// Testbench for the CPU-side bus with clock, reset, memory model, watchdog and directed tests
`timescale 1ns/10ps

module tb_nes_bus;
	import nes_timing_pkg::*;
	import nes_bus_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam addr_t IDLE_ADDR = 16'h8000;	// CPU parks on a cart read
	localparam addr_t DMC_SAMPLE_ADDR = 16'hC3A5;
	// Rough length of each test in CPU ticks
	localparam int CLOCK_TICKS = 100;
	localparam int SPRITE_TICKS = 600;
	localparam int DMC_TICKS = 600;
	localparam int JOY_TICKS = 100;
	localparam int OPEN_BUS_TICKS = 100;
	localparam int TEST_TICKS = CLOCK_TICKS + SPRITE_TICKS + DMC_TICKS + JOY_TICKS + OPEN_BUS_TICKS;
	localparam int WATCHDOG_NS = 2 * TEST_TICKS * 16 * CLK_PERIOD;	// PAL worst case per tick
	localparam int DMA_CLOCK_LIMIT = 700 * 16;

	logic clk = 1'b0;
	logic reset;
	addr_t cpu_addr;
	logic cpu_rnw;
	data_t cpu_dout;
	logic dmc_req;
	addr_t dmc_addr;
	sys_type_t sys_type;
	joy_data_t joypad1_data;
	joy_data_t joypad2_data;
	data_t mem_din;
	logic cpu_ce, ppu_ce, odd_cycle, pause_cpu, dmc_ack;
	data_t cpu_din;
	addr_t mem_addr;
	logic mem_read, mem_write;
	data_t mem_dout;
	logic [2:0] joypad_out;
	logic [1:0] joypad_clock;

	integer seed = 35;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	data_t tick_din;		// Sampled on the last clock of a CPU cycle
	logic [1:0] tick_joy_clock;
	int tick_reads;			// mem_read strobes seen in that cycle

	nes_bus_top DUT (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Memory model, every byte is a function of its full address
	function automatic data_t model_byte(input addr_t addr);
		return addr[15:8] ^ addr[7:0];
	endfunction

	assign mem_din = model_byte(mem_addr);

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("FAIL %0t: %s got %0h expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests++;
		$display("%s: %s", name, (errors == err_start) ? "passed" : "failed");
	endtask

	// Runs to the next CPU tick edge, sampling the cycle on its last clock
	task automatic cpu_tick;
		tick_reads = 0;
		do begin
			@(negedge clk);
			if (mem_read)
				tick_reads++;
		end while (!cpu_ce);
		tick_din = cpu_din;
		tick_joy_clock = joypad_clock;
		@(posedge clk);
	endtask

	task automatic drive_bus(input addr_t addr, input logic rnw, input data_t data);
		cpu_addr <= addr;
		cpu_rnw <= rnw;
		cpu_dout <= data;
	endtask

	// Clocks from the current point up to the next enable pulse
	task automatic count_period(input bit use_ppu, output int clocks);
		clocks = 0;
		do begin
			@(negedge clk);
			clocks++;
		end while (!(use_ppu ? ppu_ce : cpu_ce));
	endtask

	task automatic test_clock_ticks;
		int err_start;
		int clocks;
		int total;
		logic prev_odd;
		err_start = errors;
		@(negedge clk);
		check_value("pause_cpu after reset", 32'(pause_cpu), 0);
		check_value("dmc_ack after reset", 32'(dmc_ack), 0);
		check_value("mem_read after reset", 32'(mem_read), 0);
		check_value("mem_write after reset", 32'(mem_write), 0);
		check_value("joypad_clock after reset", 32'(joypad_clock), 0);
		count_period(0, clocks);	// Sync to a CPU tick
		prev_odd = odd_cycle;
		repeat (4) begin
			count_period(0, clocks);
			check_value("NTSC CPU period", 32'(clocks), 12);
			check_value("odd_cycle toggle", 32'(odd_cycle), 32'(!prev_odd));
			prev_odd = odd_cycle;
		end
		repeat (3) begin
			count_period(1, clocks);
			check_value("PPU period", 32'(clocks), 4);
		end
		@(posedge clk);
		sys_type <= 2'b01;	// PAL
		repeat (2) count_period(0, clocks);	// Let the counters realign
		total = 0;
		repeat (5) begin
			count_period(0, clocks);
			total += clocks;
		end
		check_value("PAL group of five", 32'(total), 64);
		@(posedge clk);
		sys_type <= 2'b00;
		repeat (2) count_period(0, clocks);
		finish_test("clock ticks", err_start);
	endtask

	// Sprite copy, with an optional DMC request in the middle
	task automatic run_sprite_dma(input string name, input bit with_dmc);
		int err_start;
		int idx;
		int acks;
		int ticks;
		int clocks;
		bit done;
		data_t page;
		addr_t last_read;
		err_start = errors;
		page = data_t'($random(seed));
		if (page == 8'h40)
			page = 8'h41;	// Keep the source outside the APU window
		idx = 0;
		acks = 0;
		ticks = 0;
		clocks = 0;
		done = 0;
		last_read = 16'h0000;
		cpu_tick();
		drive_bus(SPRITE_DMA_ADDR, 1'b0, page);
		cpu_tick();
		drive_bus(IDLE_ADDR, 1'b1, 8'h00);	// CPU holds a read while halted
		@(negedge clk);
		check_value("pause_cpu after $4014 write", 32'(pause_cpu), 1);
		while (!done && clocks < DMA_CLOCK_LIMIT) begin
			if (clocks > 0)
				@(negedge clk);
			clocks++;
			if (mem_read)
				last_read = mem_addr;
			if (mem_write && mem_addr == OAM_DATA_ADDR) begin
				check_value("sprite byte", 32'(mem_dout), 32'(model_byte({page, idx[7:0]})));
				check_value("sprite write on odd cycle", 32'(odd_cycle), 1);
				check_value("read before write", 32'(last_read), 32'({page, idx[7:0]}));
				idx++;
			end
			if (!pause_cpu) begin
				done = 1;
				check_value("writes before pause_cpu fell", 32'(idx), 256);
			end else if (cpu_ce) begin
				ticks++;
				if (dmc_ack) begin
					acks++;
					check_value("dmc_ack on even cycle", 32'(odd_cycle), 0);
					check_value("DMC address", 32'(mem_addr), 32'(DMC_SAMPLE_ADDR));
					check_value("DMC read strobe", 32'(last_read), 32'(DMC_SAMPLE_ADDR));
					check_value("DMC sample byte", 32'(cpu_din),
						32'(model_byte(DMC_SAMPLE_ADDR)));
					@(posedge clk);
					dmc_req <= 1'b0;	// Request ends with the acknowledge
				end else if (with_dmc && ticks == 100) begin
					@(posedge clk);
					dmc_req <= 1'b1;
					dmc_addr <= DMC_SAMPLE_ADDR;
				end
			end
		end
		if (!done) begin
			errors++;
			$display("Sprite DMA still running after %0d clocks", clocks);
		end
		check_value("sprite writes", 32'(idx), 256);
		check_value("DMC acknowledges", 32'(acks), with_dmc ? 1 : 0);
		finish_test(name, err_start);
	endtask

	task automatic test_joypads;
		int err_start;
		data_t strobe;
		data_t prev;
		joy_data_t pad1;
		joy_data_t pad2;
		addr_t prev_addr;
		err_start = errors;
		strobe = data_t'($random(seed));
		pad1 = joy_data_t'($random(seed));
		pad2 = joy_data_t'($random(seed));
		prev_addr = {8'hA0, data_t'($random(seed))};
		prev = model_byte(prev_addr);
		cpu_tick();
		drive_bus(JOY1_ADDR, 1'b0, strobe);
		joypad1_data <= pad1;
		joypad2_data <= pad2;
		cpu_tick();
		drive_bus(prev_addr, 1'b1, 8'h00);	// Leaves a known byte on the open bus
		@(negedge clk);
		check_value("joypad_out", 32'(joypad_out), 32'(strobe[2:0]));
		cpu_tick();
		check_value("memory read", 32'(tick_din), 32'(prev));
		drive_bus(JOY1_ADDR, 1'b1, 8'h00);
		cpu_tick();
		check_value("joypad 1 read", 32'(tick_din), 32'({prev[7:5], pad1}));
		check_value("joypad 1 clock", 32'(tick_joy_clock), 32'(2'b01));
		drive_bus(JOY2_ADDR, 1'b1, 8'h00);
		cpu_tick();
		check_value("joypad 2 read", 32'(tick_din), 32'({prev[7:5], pad2}));
		check_value("joypad 2 clock", 32'(tick_joy_clock), 32'(2'b10));
		drive_bus(IDLE_ADDR, 1'b1, 8'h00);
		finish_test("joypads", err_start);
	endtask

	task automatic test_open_bus;
		int err_start;
		addr_t addr;
		err_start = errors;
		addr = addr_t'($random(seed)) | 16'h8000;	// Cart space
		cpu_tick();
		drive_bus(addr, 1'b1, 8'h00);
		cpu_tick();
		check_value("memory read", 32'(tick_din), 32'(model_byte(addr)));
		check_value("memory read strobes", 32'(tick_reads), 1);
		drive_bus(APU_BASE, 1'b1, 8'h00);
		cpu_tick();
		check_value("open bus read", 32'(tick_din), 32'(model_byte(addr)));
		check_value("APU read strobes", 32'(tick_reads), 0);
		drive_bus(IDLE_ADDR, 1'b1, 8'h00);
		finish_test("open bus", err_start);
	endtask

	initial begin
		reset = 1'b1;
		cpu_addr = IDLE_ADDR;
		cpu_rnw = 1'b1;
		cpu_dout = 8'h00;
		dmc_req = 1'b0;
		dmc_addr = 16'h0000;
		sys_type = 2'b00;	// NTSC
		joypad1_data = 5'd0;
		joypad2_data = 5'd0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		test_clock_ticks();
		run_sprite_dma("sprite DMA", 1'b0);
		run_sprite_dma("DMC steal", 1'b1);
		test_joypads();
		test_open_bus();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Ends a hung run
	initial begin
		#(WATCHDOG_NS);
		$display("Simulation did not complete within %0d ns", WATCHDOG_NS);
		$display("Errors found");
		$finish;
	end

endmodule
